// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP       ?= tb_ecc_codec
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
+incdir+logic
logic/ecc_pkg.sv
logic/ecc_encoder.sv
logic/dec_syndrome.sv
logic/dec_overall_check.sv
logic/dec_correct.sv
logic/ecc_decoder.sv
logic/ecc_codec.sv
verification/tb_ecc_codec.sv

// File: logic/dec_correct.sv
`timescale 1ns/1ns
`include "ecc_defs.svh"

module dec_correct import ecc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  syndrome_t                  syn,
    input  check_word_t                word,
    output logic [`ECC_INFO_WIDTH-1:0] data_out,
    output err_class_e                 num_of_errors
);

    logic [`ECC_SYN_WIDTH-1:0]  s;
    logic                       o;
    logic [2:0]                 r_idx;      // Position of the overall parity bit
    err_class_e                 err_class;
    logic [`ECC_CW_WIDTH-1:0]   flip;
    logic [`ECC_CW_WIDTH-1:0]   fixed_cw;
    logic [`ECC_INFO_WIDTH-1:0] info_next;

    assign s     = syn.s;
    assign o     = word.overall;
    assign r_idx = (word.mode == MODE_NONE) ? 3'd0 : 3'(par_len(word.mode) - 1);

    always_comb begin
        if (o) begin
            err_class = ERR_SINGLE;
        end else if (s != '0) begin
            err_class = ERR_DOUBLE;             // Even parity but checks disagree
        end else begin
            err_class = ERR_NONE;
        end
    end

    // Build a one-hot flip mask over the codeword for a single error
    always_comb begin
        flip = '0;
        if (err_class == ERR_SINGLE) begin
            if (s == '0) begin
                flip[r_idx] = 1'b1;             // Overall parity bit
            end else if ((s & (s - 1'b1)) == '0) begin
                flip[`ECC_SYN_WIDTH-1:0] = s;   // Check bit j sits at position j
            end else begin
                for (int i = 0; i < `ECC_INFO_WIDTH; i++) begin
                    if (i < info_len(word.mode) && info_column(i) == s) begin
                        flip[r_idx + 1 + i] = 1'b1;
                    end
                end
            end
        end
    end

    assign fixed_cw = word.cw ^ flip;

    // Drop the parity field and zero-pad the info field
    always_comb begin
        case (word.mode)
            MODE_8_4: begin
                info_next = {22'b0, fixed_cw[7:4]};
            end
            MODE_16_11: begin
                info_next = {15'b0, fixed_cw[15:5]};
            end
            MODE_32_26: begin
                info_next = fixed_cw[31:6];
            end
            default: begin
                info_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_out      <= '0;
            num_of_errors <= ERR_NONE;
        end else begin
            data_out      <= info_next;
            num_of_errors <= err_class;
        end
    end

endmodule

// File: logic/dec_overall_check.sv
`timescale 1ns/1ns
`include "ecc_defs.svh"

module dec_overall_check import ecc_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`ECC_CW_WIDTH-1:0] data_in,
    input  ecc_mode_e                mod,
    output check_word_t              word
);

    logic [`ECC_CW_WIDTH-1:0] len_mask;
    logic [`ECC_CW_WIDTH-1:0] masked;

    always_comb begin
        case (mod)
            MODE_8_4:   len_mask = 32'h0000_00ff;
            MODE_16_11: len_mask = 32'h0000_ffff;
            MODE_32_26: len_mask = 32'hffff_ffff;
            default:    len_mask = 32'h0000_0000;
        endcase
    end

    assign masked = data_in & len_mask;  // Bits past the code length are ignored

    always_ff @(posedge clk) begin
        if (rst) begin
            word.cw      <= '0;
            word.mode    <= MODE_NONE;
            word.overall <= 1'b0;
        end else begin
            word.cw      <= masked;
            word.mode    <= mod;
            word.overall <= ^masked;
        end
    end

endmodule

// File: logic/dec_syndrome.sv
`timescale 1ns/1ns
`include "ecc_defs.svh"

module dec_syndrome import ecc_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`ECC_CW_WIDTH-1:0] data_in,
    input  ecc_mode_e                mod,
    output syndrome_t                syn
);

    logic [`ECC_INFO_WIDTH-1:0] rx_info;
    logic [`ECC_SYN_WIDTH-1:0]  rx_checks;
    logic [`ECC_SYN_WIDTH-1:0]  calc_checks;
    syndrome_t                  syn_next;

    // Split the word into info and check fields, overall bit skipped
    always_comb begin
        case (mod)
            MODE_8_4: begin
                rx_info   = {22'b0, data_in[7:4]};
                rx_checks = {2'b0, data_in[2:0]};
            end
            MODE_16_11: begin
                rx_info   = {15'b0, data_in[15:5]};
                rx_checks = {1'b0, data_in[3:0]};
            end
            MODE_32_26: begin
                rx_info   = data_in[31:6];
                rx_checks = data_in[4:0];
            end
            default: begin
                rx_info   = '0;
                rx_checks = '0;
            end
        endcase
    end

    assign calc_checks = hamming_checks(rx_info, mod);
    assign syn_next.s  = calc_checks ^ rx_checks;

    always_ff @(posedge clk) begin
        if (rst) begin
            syn <= '0;
        end else begin
            syn <= syn_next;
        end
    end

endmodule

// File: logic/ecc_codec.sv
`timescale 1ns/1ns
`include "ecc_defs.svh"

module ecc_codec import ecc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ECC_INFO_WIDTH-1:0] info_in,
    input  ecc_mode_e                  enc_mode,
    output logic [`ECC_CW_WIDTH-1:0]   codeword_out,
    input  logic [`ECC_CW_WIDTH-1:0]   data_in,
    input  ecc_mode_e                  mod,
    output logic [`ECC_INFO_WIDTH-1:0] data_out,
    output err_class_e                 num_of_errors
);

    ecc_encoder i_ecc_encoder (
        .clk          (clk),
        .rst          (rst),
        .info_in      (info_in),
        .mode         (enc_mode),
        .codeword_out (codeword_out)
    );

    // Decode path runs independently of the encoder
    ecc_decoder i_ecc_decoder (
        .clk           (clk),
        .rst           (rst),
        .data_in       (data_in),
        .mod           (mod),
        .data_out      (data_out),
        .num_of_errors (num_of_errors)
    );

endmodule

// File: logic/ecc_decoder.sv
`timescale 1ns/1ns
`include "ecc_defs.svh"

module ecc_decoder import ecc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ECC_CW_WIDTH-1:0]   data_in,
    input  ecc_mode_e                  mod,
    output logic [`ECC_INFO_WIDTH-1:0] data_out,
    output err_class_e                 num_of_errors
);

    syndrome_t   syn;
    check_word_t word;

    // Both check units register on the same edge, so syn and word stay aligned
    dec_syndrome i_dec_syndrome (
        .clk     (clk),
        .rst     (rst),
        .data_in (data_in),
        .mod     (mod),
        .syn     (syn)
    );

    dec_overall_check i_dec_overall_check (
        .clk     (clk),
        .rst     (rst),
        .data_in (data_in),
        .mod     (mod),
        .word    (word)
    );

    dec_correct i_dec_correct (
        .clk           (clk),
        .rst           (rst),
        .syn           (syn),
        .word          (word),
        .data_out      (data_out),
        .num_of_errors (num_of_errors)
    );

endmodule

// File: logic/ecc_defs.svh
`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// Widest code is (32,26)
`define ECC_CW_WIDTH    32
`define ECC_INFO_WIDTH  26
`define ECC_PAR_WIDTH   6

// Hamming checks without the overall parity bit
`define ECC_SYN_WIDTH   (`ECC_PAR_WIDTH - 1)

`endif

// File: logic/ecc_encoder.sv
`timescale 1ns/1ns
`include "ecc_defs.svh"

module ecc_encoder import ecc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ECC_INFO_WIDTH-1:0] info_in,
    input  ecc_mode_e                  mode,
    output logic [`ECC_CW_WIDTH-1:0]   codeword_out
);

    logic [`ECC_INFO_WIDTH-1:0] info_mask;
    logic [`ECC_INFO_WIDTH-1:0] info_m;
    logic [`ECC_SYN_WIDTH-1:0]  checks;
    logic                       overall;
    logic [`ECC_CW_WIDTH-1:0]   cw_next;

    assign info_mask = `ECC_INFO_WIDTH'((33'd1 << info_len(mode)) - 33'd1);
    assign info_m    = info_in & info_mask;
    assign checks    = hamming_checks(info_m, mode);
    assign overall   = ^{info_m, checks};  // Unused upper bits are already zero

    always_comb begin
        case (mode)
            MODE_8_4: begin
                cw_next = {24'b0, info_m[3:0], overall, checks[2:0]};
            end
            MODE_16_11: begin
                cw_next = {16'b0, info_m[10:0], overall, checks[3:0]};
            end
            MODE_32_26: begin
                cw_next = {info_m[25:0], overall, checks[4:0]};
            end
            default: begin
                cw_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            codeword_out <= '0;
        end else begin
            codeword_out <= cw_next;
        end
    end

endmodule

// File: logic/ecc_pkg.sv
`include "ecc_defs.svh"

package ecc_pkg;

    typedef enum logic [1:0] {
        MODE_8_4   = 2'd0,
        MODE_16_11 = 2'd1,
        MODE_32_26 = 2'd2,
        MODE_NONE  = 2'd3
    } ecc_mode_e;

    typedef enum logic [1:0] {
        ERR_NONE   = 2'd0,
        ERR_SINGLE = 2'd1,
        ERR_DOUBLE = 2'd2
    } err_class_e;

    typedef struct packed {
        logic [`ECC_CW_WIDTH-1:0] cw;       // Masked to mode length
        ecc_mode_e                mode;
        logic                     overall;  // XOR of all codeword bits
    } check_word_t;

    typedef struct packed {
        logic [`ECC_SYN_WIDTH-1:0] s;
    } syndrome_t;

    function automatic int info_len(input ecc_mode_e mode);
        case (mode)
            MODE_8_4:   return 4;
            MODE_16_11: return 11;
            MODE_32_26: return 26;
            default:    return 0;
        endcase
    endfunction

    function automatic int par_len(input ecc_mode_e mode);
        case (mode)
            MODE_8_4:   return 4;
            MODE_16_11: return 5;
            MODE_32_26: return 6;
            default:    return 0;
        endcase
    endfunction

    // Columns are numbers with two or more bits set, in increasing order.
    // Shorter codes use a prefix of the same order
    function automatic logic [`ECC_SYN_WIDTH-1:0] info_column(input int idx);
        int                        seen;
        logic [`ECC_SYN_WIDTH-1:0] cand;
        logic [`ECC_SYN_WIDTH-1:0] col;
        seen = 0;
        col  = '0;
        for (int v = 0; v < (1 << `ECC_SYN_WIDTH); v++) begin
            cand = `ECC_SYN_WIDTH'(v);
            if ($countones(cand) >= 2) begin
                if (seen == idx) begin
                    col = cand;
                end
                seen++;
            end
        end
        return col;
    endfunction

    function automatic logic [`ECC_SYN_WIDTH-1:0] hamming_checks(
        input logic [`ECC_INFO_WIDTH-1:0] info,
        input ecc_mode_e                  mode
    );
        logic [`ECC_SYN_WIDTH-1:0] chk;
        chk = '0;
        for (int i = 0; i < `ECC_INFO_WIDTH; i++) begin
            if (i < info_len(mode) && info[i]) begin
                chk ^= info_column(i);
            end
        end
        return chk;
    endfunction

endpackage

// File: verification/tb_ecc_codec.sv
`timescale 1ns/1ns
`include "ecc_defs.svh"

module tb_ecc_codec import ecc_pkg::*; ();

    localparam int N_RAND   = 16;
    localparam int N_STREAM = 40;
    // Encode, clean and double per mode, 56 single-bit words, stream, two resets
    localparam int TOTAL_WORDS     = 9 * N_RAND + 1 + 56 + N_STREAM + 2 + 10;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 4 + 100;

    logic                       clk;
    logic                       rst;
    logic [`ECC_INFO_WIDTH-1:0] info_in;
    ecc_mode_e                  enc_mode;
    logic [`ECC_CW_WIDTH-1:0]   codeword_out;
    logic [`ECC_CW_WIDTH-1:0]   data_in;
    ecc_mode_e                  mod;
    logic [`ECC_INFO_WIDTH-1:0] data_out;
    err_class_e                 num_of_errors;

    int seed;
    int errors;

    ecc_codec i_ecc_codec (
        .clk           (clk),
        .rst           (rst),
        .info_in       (info_in),
        .enc_mode      (enc_mode),
        .codeword_out  (codeword_out),
        .data_in       (data_in),
        .mod           (mod),
        .data_out      (data_out),
        .num_of_errors (num_of_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int code_len(input ecc_mode_e m);
        case (m)
            MODE_8_4:   return 8;
            MODE_16_11: return 16;
            MODE_32_26: return 32;
            default:    return 0;
        endcase
    endfunction

    function automatic int parity_bits(input ecc_mode_e m);
        case (m)
            MODE_8_4:   return 4;
            MODE_16_11: return 5;
            MODE_32_26: return 6;
            default:    return 0;
        endcase
    endfunction

    function automatic logic [31:0] len_mask(input ecc_mode_e m);
        logic [31:0] mask;
        mask = '0;
        for (int b = 0; b < code_len(m); b++) begin
            mask[b] = 1'b1;
        end
        return mask;
    endfunction

    // idx-th r-bit value with two or more ones, counted upward
    function automatic int nth_column(input int idx, input int r);
        int found;
        found = 0;
        for (int v = 0; v < (1 << r); v++) begin
            if ($countones(v) >= 2) begin
                if (found == idx) begin
                    return v;
                end
                found++;
            end
        end
        return 0;
    endfunction

    function automatic logic [31:0] model_encode(input logic [25:0] info, input ecc_mode_e m);
        logic [31:0] cw;
        int          k;
        int          r;
        int          col;
        cw = '0;
        if (m == MODE_NONE) begin
            return cw;
        end
        k = parity_bits(m);
        r = k - 1;
        for (int i = 0; i < code_len(m) - k; i++) begin
            cw[k + i] = info[i];
            if (info[i]) begin
                col = nth_column(i, r);
                for (int j = 0; j < r; j++) begin
                    if (col[j]) begin
                        cw[j] = ~cw[j];
                    end
                end
            end
        end
        cw[r] = ^cw;  // Even parity over the whole codeword
        return cw;
    endfunction

    function automatic logic [25:0] info_field(input logic [31:0] cw, input ecc_mode_e m);
        logic [25:0] f;
        f = '0;
        for (int i = 0; i < code_len(m) - parity_bits(m); i++) begin
            f[i] = cw[parity_bits(m) + i];
        end
        return f;
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic encode_word(input logic [25:0] info, input ecc_mode_e m);
        logic [31:0] exp;
        exp = model_encode(info, m);
        @(posedge clk);
        info_in  <= info;
        enc_mode <= m;
        @(posedge clk);
        @(negedge clk);
        check_value(codeword_out, exp, $sformatf("encode %s info %h", m.name(), info));
        check_value(codeword_out & ~len_mask(m), 32'd0, "encode bits above code length");
    endtask

    task automatic decode_word(input logic [31:0] rx, input ecc_mode_e m,
                               input logic [25:0] exp_data, input err_class_e exp_err,
                               input string what);
        @(posedge clk);
        data_in <= rx;
        mod     <= m;
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
        check_value({6'b0, data_out}, {6'b0, exp_data}, {what, " data"});
        check_value({30'b0, num_of_errors}, {30'b0, exp_err}, {what, " error class"});
    endtask

    task automatic reset_hold();
        @(posedge clk);
        rst      <= 1'b1;
        info_in  <= 26'($random(seed));
        enc_mode <= MODE_32_26;
        data_in  <= 32'($random(seed));
        mod      <= MODE_32_26;
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            if (c == 3) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_value(codeword_out, 32'd0, "codeword_out in reset");
            check_value({6'b0, data_out}, 32'd0, "data_out in reset");
            check_value({30'b0, num_of_errors}, {30'b0, ERR_NONE}, "num_of_errors in reset");
        end
    endtask

    task automatic random_encodes(input ecc_mode_e m);
        for (int n = 0; n < N_RAND; n++) begin
            encode_word(26'($random(seed)), m);  // Upper info bits left random
        end
    endtask

    task automatic clean_decodes(input ecc_mode_e m);
        logic [31:0] cw;
        logic [31:0] rx;
        for (int n = 0; n < N_RAND; n++) begin
            cw = model_encode(26'($random(seed)), m);
            rx = cw | (32'($random(seed)) & ~len_mask(m));  // Junk above the code
            decode_word(rx, m, info_field(cw, m), ERR_NONE, $sformatf("clean %s", m.name()));
        end
    endtask

    task automatic single_bit_flips(input ecc_mode_e m);
        logic [31:0] cw;
        for (int b = 0; b < code_len(m); b++) begin
            cw = model_encode(26'($random(seed)), m);
            decode_word(cw ^ (32'd1 << b), m, info_field(cw, m), ERR_SINGLE,
                        $sformatf("single %s bit %0d", m.name(), b));
        end
    endtask

    task automatic double_bit_flips(input ecc_mode_e m);
        logic [31:0] rx;
        int          a;
        int          b;
        for (int n = 0; n < N_RAND; n++) begin
            a = rand_below(code_len(m));
            b = rand_below(code_len(m));
            while (b == a) begin
                b = rand_below(code_len(m));
            end
            rx = model_encode(26'($random(seed)), m) ^ (32'd1 << a) ^ (32'd1 << b);
            decode_word(rx, m, info_field(rx, m), ERR_DOUBLE,
                        $sformatf("double %s bits %0d %0d", m.name(), a, b));
        end
    endtask

    task automatic mixed_stream();
        logic [31:0] rx_q [N_STREAM];
        ecc_mode_e   mode_q [N_STREAM];
        logic [25:0] data_q [N_STREAM];
        err_class_e  err_q [N_STREAM];
        logic [1:0]  mcode;
        logic [31:0] cw;
        int          kind;
        int          a;
        int          b;
        mcode = 2'd2;
        for (int t = 0; t < N_STREAM; t++) begin
            mcode     = mcode + 2'd1 + 2'(rand_below(3));  // Never repeats the last mode
            mode_q[t] = ecc_mode_e'(mcode);
            cw        = model_encode(26'($random(seed)), mode_q[t]);
            kind      = (mode_q[t] == MODE_NONE) ? 0 : rand_below(3);
            a         = rand_below(code_len(mode_q[t]) + 1);
            b         = 0;
            if (kind == 2) begin
                a = rand_below(code_len(mode_q[t]));
                b = (a + 1 + rand_below(code_len(mode_q[t]) - 1)) % code_len(mode_q[t]);
            end
            rx_q[t]   = cw;
            data_q[t] = info_field(cw, mode_q[t]);
            err_q[t]  = ERR_NONE;
            if (kind == 1) begin
                rx_q[t]  = cw ^ (32'd1 << (a % code_len(mode_q[t])));
                err_q[t] = ERR_SINGLE;
            end else if (kind == 2) begin
                rx_q[t]   = cw ^ (32'd1 << a) ^ (32'd1 << b);
                data_q[t] = info_field(rx_q[t], mode_q[t]);
                err_q[t]  = ERR_DOUBLE;
            end
            rx_q[t] = rx_q[t] | (32'($random(seed)) & ~len_mask(mode_q[t]));
        end
        for (int t = 0; t < N_STREAM + 2; t++) begin
            @(posedge clk);
            if (t < N_STREAM) begin
                data_in <= rx_q[t];
                mod     <= mode_q[t];
            end
            @(negedge clk);
            if (t >= 2) begin  // Word t-2 is due now
                check_value({6'b0, data_out}, {6'b0, data_q[t-2]},
                            $sformatf("stream word %0d data", t - 2));
                check_value({30'b0, num_of_errors}, {30'b0, err_q[t-2]},
                            $sformatf("stream word %0d error class", t - 2));
            end
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        ecc_mode_e m;
        seed     = 24003;
        errors   = 0;
        rst      = 1'b1;
        info_in  = '0;
        enc_mode = MODE_NONE;
        data_in  = '0;
        mod      = MODE_NONE;
        reset_hold();
        for (int mi = 0; mi < 3; mi++) begin
            m = ecc_mode_e'(2'(mi));
            random_encodes(m);
            clean_decodes(m);
            single_bit_flips(m);
            double_bit_flips(m);
        end
        encode_word(26'($random(seed)), MODE_NONE);
        mixed_stream();
        reset_hold();
        $display("Checks done, %0d error(s)", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
